// ==== all.f ====
logic/devinfo_types_pkg.sv
logic/icap_cmd_pkg.sv
logic/dna_reader.sv
logic/icap_idcode_reader.sv
logic/device_info.sv
verification/device_info_asserts.sv
verification/device_info_tb.sv

// ==== logic/device_info.sv ====
`timescale 1ns/1ps

module device_info #(
	parameter int dna_boot_cycles  = 128,
	parameter int icap_boot_cycles = 65536
) (
	input  logic                           clk,
	input  logic                           rst_n,

	// device-dna primitive pins
	input  logic                           dna_dout,
	output logic                           dna_read,
	output logic                           dna_shift,

	// icap primitive pins, data bit-swapped per byte
	output devinfo_types_pkg::icap_word_t  icap_i,
	output logic                           icap_csib,
	output logic                           icap_rdwrb,
	input  devinfo_types_pkg::icap_word_t  icap_o,

	// held identity values
	output devinfo_types_pkg::die_serial_t die_serial,
	output logic                           serial_valid,
	output devinfo_types_pkg::idcode_t     idcode,
	output logic                           idcode_valid
);

	////////////////////////////////////////////////////////////////////////////
	// die serial number

	dna_reader #(
		.dna_boot_cycles (dna_boot_cycles)
	) dna_rd_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.dna_dout     (dna_dout),
		.dna_read     (dna_read),
		.dna_shift    (dna_shift),
		.die_serial   (die_serial),
		.serial_valid (serial_valid)
	);

	////////////////////////////////////////////////////////////////////////////
	// idcode over icap

	icap_idcode_reader #(
		.icap_boot_cycles (icap_boot_cycles)
	) icap_rd_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.icap_i       (icap_i),
		.icap_csib    (icap_csib),
		.icap_rdwrb   (icap_rdwrb),
		.icap_o       (icap_o),
		.idcode       (idcode),
		.idcode_valid (idcode_valid)
	);

endmodule

// ==== logic/devinfo_types_pkg.sv ====
package devinfo_types_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths of the identity values

	// published serial is padded out to a full 64-bit word
	localparam int serial_width = 64;

	// bits actually held in the device-DNA register
	localparam int dna_bits = 57;

	// jtag idcode
	localparam int idcode_width = 32;

	////////////////////////////////////////////////////////////////////////////
	// icap data path

	// x32 port width
	localparam int icap_width = 32;

	// bit order is reversed inside each byte of this size
	localparam int icap_byte_width = 8;

	////////////////////////////////////////////////////////////////////////////
	// vector types

	// dna bits sit right-aligned, upper bits stay zero
	typedef logic [serial_width-1:0] die_serial_t;

	// idcode in normal bit order
	typedef logic [idcode_width-1:0] idcode_t;

	// one icap word, swapped or not
	typedef logic [icap_width-1:0] icap_word_t;

endpackage

// ==== logic/dna_reader.sv ====
`timescale 1ns/1ps

module dna_reader #(
	parameter int dna_boot_cycles = 128
) (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            dna_dout,
	output logic                            dna_read,
	output logic                            dna_shift,
	output devinfo_types_pkg::die_serial_t  die_serial,
	output logic                            serial_valid
);

	// one counter covers both the boot wait and the bit count
	localparam int cnt_max = (dna_boot_cycles > devinfo_types_pkg::dna_bits) ?
		dna_boot_cycles : devinfo_types_pkg::dna_bits;
	localparam int cnt_w = $clog2(cnt_max + 1);

	localparam logic [cnt_w-1:0] boot_last = cnt_w'(dna_boot_cycles - 1);
	localparam logic [cnt_w-1:0] bit_last = cnt_w'(devinfo_types_pkg::dna_bits - 1);

	localparam int serial_msb = devinfo_types_pkg::serial_width - 1;

	typedef enum logic [1:0] {
		boot_wait  = 2'd0,
		read_pulse = 2'd1,
		shift_in   = 2'd2,
		done       = 2'd3
	} dna_state_t;

	dna_state_t       state;
	logic [cnt_w-1:0] cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= boot_wait;
			cnt          <= '0;
			dna_read     <= 1'b0;
			dna_shift    <= 1'b0;
			die_serial   <= '0;
			serial_valid <= 1'b0;
		end else begin
			// both strobes are single-cycle unless a state holds them
			dna_read  <= 1'b0;
			dna_shift <= 1'b0;

			case (state)
				// let the primitive settle after power-up
				boot_wait: begin
					cnt <= cnt + 1'b1;
					if (cnt == boot_last) begin
						dna_read <= 1'b1;
						cnt      <= '0;
						state    <= read_pulse;
					end
				end

				// primitive loads on this edge, msb shows next
				read_pulse: begin
					dna_shift <= 1'b1;
					state     <= shift_in;
				end

				// msb first, one bit per edge
				shift_in: begin
					die_serial <= {die_serial[serial_msb-1:0], dna_dout};
					cnt        <= cnt + 1'b1;
					if (cnt == bit_last)
						state <= done;
					else
						dna_shift <= 1'b1;
				end

				// hold result until next reset
				done: begin
					serial_valid <= 1'b1;
				end

				default: state <= boot_wait;
			endcase
		end
	end

endmodule

// ==== logic/icap_cmd_pkg.sv ====
package icap_cmd_pkg;

	////////////////////////////////////////////////////////////////////////////
	// configuration packet words, normal bit order

	// sync word opens the packet stream
	localparam devinfo_types_pkg::icap_word_t sync_word = 32'haa99_5566;

	// type 1 nop
	localparam devinfo_types_pkg::icap_word_t nop_word = 32'h2000_0000;

	// type 1 read of the idcode register, one word
	localparam devinfo_types_pkg::icap_word_t idcode_read_hdr = 32'h2801_8001;

	// type 1 write to the cmd register, one word
	localparam devinfo_types_pkg::icap_word_t cmd_write_hdr = 32'h3000_8001;

	// cmd register code for desync
	localparam devinfo_types_pkg::icap_word_t desync_cmd = 32'h0000_000d;

	// read cycle on which the returned word is sampled
	localparam int read_capture_offset = 3;

	// icap reader sequencer
	typedef enum logic [2:0] {
		boot_hold = 3'd0,
		sync      = 3'd1,
		nop       = 3'd2,
		header    = 3'd3,
		pipe      = 3'd4,
		read      = 3'd5,
		desync    = 3'd6
	} icap_state_t;

endpackage

// ==== logic/icap_idcode_reader.sv ====
`timescale 1ns/1ps

module icap_idcode_reader #(
	parameter int icap_boot_cycles = 65536
) (
	input  logic                           clk,
	input  logic                           rst_n,
	output devinfo_types_pkg::icap_word_t  icap_i,
	output logic                           icap_csib,
	output logic                           icap_rdwrb,
	input  devinfo_types_pkg::icap_word_t  icap_o,
	output devinfo_types_pkg::idcode_t     idcode,
	output logic                           idcode_valid
);

	localparam int boot_w = $clog2(icap_boot_cycles + 1);
	localparam logic [boot_w-1:0] boot_last = boot_w'(icap_boot_cycles - 1);

	typedef logic [3:0] step_t;

	// pipe state steps
	localparam step_t nop_last      = 4'd1;
	localparam step_t pipe_cs_off   = 4'd2;
	localparam step_t pipe_rd_mode  = 4'd3;
	localparam step_t pipe_last     = 4'd4;
	localparam step_t capture_step  = step_t'(icap_cmd_pkg::read_capture_offset);

	// desync state steps
	localparam step_t ds_cs_off     = 4'd0;
	localparam step_t ds_wr_mode    = 4'd1;
	localparam step_t ds_cs_on      = 4'd2;
	localparam step_t ds_hdr        = 4'd3;
	localparam step_t ds_cmd        = 4'd4;
	localparam step_t ds_nop        = 4'd5;
	localparam step_t ds_cs_rel     = 4'd7;
	localparam step_t ds_end        = 4'd8;

	icap_cmd_pkg::icap_state_t     state;
	logic [boot_w-1:0]             boot_cnt;
	step_t                         step;
	devinfo_types_pkg::icap_word_t cmd_word;

	// icap wants each byte with its bits mirrored, in both directions
	function automatic devinfo_types_pkg::icap_word_t byte_bitswap(
		input devinfo_types_pkg::icap_word_t w
	);
		devinfo_types_pkg::icap_word_t r;
		r = '0;
		for (int b = 0; b < devinfo_types_pkg::icap_width / devinfo_types_pkg::icap_byte_width;
				b++) begin
			for (int g = 0; g < devinfo_types_pkg::icap_byte_width; g++) begin
				r[b * devinfo_types_pkg::icap_byte_width + g] =
					w[b * devinfo_types_pkg::icap_byte_width +
					devinfo_types_pkg::icap_byte_width - 1 - g];
			end
		end
		return r;
	endfunction

	assign icap_i = byte_bitswap(cmd_word);

	////////////////////////////////////////////////////////////////////////////
	// command sequencer

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= icap_cmd_pkg::boot_hold;
			boot_cnt     <= '0;
			step         <= '0;
			cmd_word     <= icap_cmd_pkg::nop_word;
			icap_csib    <= 1'b1;
			icap_rdwrb   <= 1'b1;
			idcode       <= '0;
			idcode_valid <= 1'b0;
		end else begin
			case (state)
				// long hold, port is not usable right after configuration
				icap_cmd_pkg::boot_hold: begin
					boot_cnt <= boot_cnt + 1'b1;
					if (boot_cnt == boot_last) begin
						// write mode first, select follows a cycle later
						icap_rdwrb <= 1'b0;
						state      <= icap_cmd_pkg::sync;
					end
				end

				// sync word goes out on the first selected edge
				icap_cmd_pkg::sync: begin
					icap_csib <= 1'b0;
					cmd_word  <= icap_cmd_pkg::sync_word;
					step      <= '0;
					state     <= icap_cmd_pkg::nop;
				end

				// two nops cover the hazard after sync
				icap_cmd_pkg::nop: begin
					cmd_word <= icap_cmd_pkg::nop_word;
					step     <= step + 1'b1;
					if (step == nop_last)
						state <= icap_cmd_pkg::header;
				end

				// ask for the idcode register
				icap_cmd_pkg::header: begin
					cmd_word <= icap_cmd_pkg::idcode_read_hdr;
					step     <= '0;
					state    <= icap_cmd_pkg::pipe;
				end

				// flush with nops, then turn the port around for reading
				icap_cmd_pkg::pipe: begin
					cmd_word <= icap_cmd_pkg::nop_word;
					step     <= step + 1'b1;
					if (step == pipe_cs_off)
						icap_csib <= 1'b1;
					if (step == pipe_rd_mode)
						icap_rdwrb <= 1'b1;
					if (step == pipe_last) begin
						icap_csib <= 1'b0;
						step      <= '0;
						state     <= icap_cmd_pkg::read;
					end
				end

				// read latency, sample once the word has arrived
				icap_cmd_pkg::read: begin
					step <= step + 1'b1;
					if (step == capture_step) begin
						idcode       <= byte_bitswap(icap_o);
						idcode_valid <= 1'b1;
						step         <= '0;
						state        <= icap_cmd_pkg::desync;
					end
				end

				// back to write mode, desync, release the port
				icap_cmd_pkg::desync: begin
					if (step != ds_end)
						step <= step + 1'b1;
					case (step)
						ds_cs_off:  icap_csib <= 1'b1;
						ds_wr_mode: icap_rdwrb <= 1'b0;
						ds_cs_on: begin
							icap_csib <= 1'b0;
							cmd_word  <= icap_cmd_pkg::nop_word;
						end
						ds_hdr:     cmd_word <= icap_cmd_pkg::cmd_write_hdr;
						ds_cmd:     cmd_word <= icap_cmd_pkg::desync_cmd;
						ds_nop:     cmd_word <= icap_cmd_pkg::nop_word;
						ds_cs_rel:  icap_csib <= 1'b1;
						default: begin
						end
					endcase
				end

				default: state <= icap_cmd_pkg::boot_hold;
			endcase
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module device_info_tb \
	-f all.f -o device_info_sim \
	&& ./obj_dir/device_info_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TB PASSED" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== verification/device_info_asserts.sv ====
`timescale 1ns/1ps

module device_info_asserts (
	input logic                           clk,
	input logic                           rst_n,
	input logic                           dna_read,
	input logic                           dna_shift,
	input devinfo_types_pkg::die_serial_t die_serial,
	input logic                           serial_valid,
	input devinfo_types_pkg::idcode_t     idcode,
	input logic                           idcode_valid,
	input logic                           icap_csib,
	input logic                           icap_rdwrb,
	input icap_cmd_pkg::icap_state_t      icap_state
);

	// dna load and shift never overlap
	read_shift_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(dna_read && dna_shift))
		else $error("dna_read and dna_shift high together");

	// results are held once published
	serial_held: assert property (@(posedge clk) disable iff (!rst_n)
		serial_valid |=> serial_valid && $stable(die_serial))
		else $error("serial_valid dropped or die_serial changed");

	idcode_held: assert property (@(posedge clk) disable iff (!rst_n)
		idcode_valid |=> idcode_valid && $stable(idcode))
		else $error("idcode_valid dropped or idcode changed");

	// direction only turns while deselected on both sides of the change
	rdwrb_turn: assert property (@(posedge clk) disable iff (!rst_n)
		!$stable(icap_rdwrb) |-> icap_csib && $past(icap_csib))
		else $error("icap_rdwrb changed while icap_csib low");

	boot_idle: assert property (@(posedge clk) disable iff (!rst_n)
		(icap_state == icap_cmd_pkg::boot_hold) |-> icap_csib)
		else $error("icap selected during boot hold");

endmodule

bind device_info device_info_asserts asserts_i (
	.clk          (clk),
	.rst_n        (rst_n),
	.dna_read     (dna_read),
	.dna_shift    (dna_shift),
	.die_serial   (die_serial),
	.serial_valid (serial_valid),
	.idcode       (idcode),
	.idcode_valid (idcode_valid),
	.icap_csib    (icap_csib),
	.icap_rdwrb   (icap_rdwrb),
	.icap_state   (icap_rd_i.state)
);

// ==== verification/device_info_tb.sv ====
`timescale 1ns/1ps

module device_info_tb;

	localparam int dna_boot = 128;
	localparam int icap_boot = 256;
	localparam int num_tests = 6;
	// vector line whose run gets cut short by a reset during the icap read
	localparam int abort_at = 3;
	localparam int timeout_cycles = num_tests * (icap_boot + 300);
	localparam devinfo_types_pkg::icap_word_t idle_word = 32'hdead_beef;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	logic dna_dout = 1'b0;
	devinfo_types_pkg::icap_word_t icap_o = 32'hdead_beef;

	logic                          dna_read;
	logic                          dna_shift;
	devinfo_types_pkg::icap_word_t icap_i;
	logic                          icap_csib;
	logic                          icap_rdwrb;
	devinfo_types_pkg::die_serial_t die_serial;
	logic                          serial_valid;
	devinfo_types_pkg::idcode_t    idcode;
	logic                          idcode_valid;

	// two entries per vector line, serial then idcode
	logic [63:0] vectors [0:2*num_tests-1];
	logic [devinfo_types_pkg::dna_bits-1:0] cur_serial;
	devinfo_types_pkg::idcode_t cur_idcode;

	logic [devinfo_types_pkg::dna_bits-1:0] dna_reg;
	devinfo_types_pkg::icap_word_t accepted_q [$];
	logic synced;
	logic armed;
	logic desync_seen;
	int   rd_cnt;
	int   read_pulses;
	int   shift_cycles;
	int   run_cycles = 0;
	int   err_count = 0;
	int   tests_run = 0;
	int   tests_failed = 0;

	device_info #(
		.dna_boot_cycles  (dna_boot),
		.icap_boot_cycles (icap_boot)
	) dut_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.dna_dout     (dna_dout),
		.dna_read     (dna_read),
		.dna_shift    (dna_shift),
		.icap_i       (icap_i),
		.icap_csib    (icap_csib),
		.icap_rdwrb   (icap_rdwrb),
		.icap_o       (icap_o),
		.die_serial   (die_serial),
		.serial_valid (serial_valid),
		.idcode       (idcode),
		.idcode_valid (idcode_valid)
	);

	always #4 clk = ~clk;

	// mirror bits inside each byte, same in both directions
	function automatic devinfo_types_pkg::icap_word_t mirror_bytes(
		input devinfo_types_pkg::icap_word_t w
	);
		devinfo_types_pkg::icap_word_t r;
		for (int k = 0; k < 4; k++)
			r[8*k +: 8] = {<<{w[8*k +: 8]}};
		return r;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// primitive models

	// dna register, load on read, shift left on shift, msb on dout
	always @(posedge clk) begin
		if (!rst_n) begin
			dna_reg  <= '0;
			dna_dout <= 1'b0;
		end else if (dna_read) begin
			dna_reg  <= cur_serial;
			dna_dout <= cur_serial[devinfo_types_pkg::dna_bits-1];
		end else if (dna_shift) begin
			dna_reg  <= {dna_reg[devinfo_types_pkg::dna_bits-2:0], 1'b0};
			dna_dout <= dna_reg[devinfo_types_pkg::dna_bits-2];
		end
	end

	// icap, logs written words and answers the idcode read
	always @(posedge clk) begin : icap_model
		devinfo_types_pkg::icap_word_t rx_word;
		if (!rst_n) begin
			accepted_q.delete();
			synced      <= 1'b0;
			armed       <= 1'b0;
			desync_seen <= 1'b0;
			rd_cnt      <= 0;
			icap_o      <= idle_word;
		end else if (!icap_csib && !icap_rdwrb) begin
			rx_word = mirror_bytes(icap_i);
			accepted_q.push_back(rx_word);
			if (rx_word == icap_cmd_pkg::sync_word)
				synced <= 1'b1;
			if (synced && rx_word == icap_cmd_pkg::idcode_read_hdr)
				armed <= 1'b1;
			if (rx_word == icap_cmd_pkg::desync_cmd) begin
				desync_seen <= 1'b1;
				synced      <= 1'b0;
				armed       <= 1'b0;
			end
		end else if (!icap_csib && icap_rdwrb && armed) begin
			// data shows from the third read edge on
			if (rd_cnt == 2)
				icap_o <= mirror_bytes(cur_idcode);
			rd_cnt <= rd_cnt + 1;
		end else if (icap_csib) begin
			rd_cnt <= 0;
			icap_o <= idle_word;
		end
	end

	// dna strobe counts per reset
	always @(posedge clk) begin
		if (!rst_n) begin
			read_pulses  <= 0;
			shift_cycles <= 0;
		end else begin
			if (dna_read)
				read_pulses <= read_pulses + 1;
			if (dna_shift)
				shift_cycles <= shift_cycles + 1;
		end
	end

	always @(posedge clk) begin
		run_cycles <= run_cycles + 1;
		if (run_cycles >= timeout_cycles) begin
			$display("timeout: tests did not finish within %0d cycles", timeout_cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// compare tasks

	task automatic check_serial(input string name, input devinfo_types_pkg::die_serial_t got,
			input devinfo_types_pkg::die_serial_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			err_count++;
		end
	endtask

	task automatic check_idcode(input string name, input devinfo_types_pkg::idcode_t got,
			input devinfo_types_pkg::idcode_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			err_count++;
		end
	endtask

	task automatic check_word(input string name, input devinfo_types_pkg::icap_word_t got,
			input devinfo_types_pkg::icap_word_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			err_count++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
			err_count++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
			err_count++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test steps

	task automatic load_vector(input int idx);
		cur_serial = vectors[2*idx][devinfo_types_pkg::dna_bits-1:0];
		cur_idcode = vectors[2*idx+1][31:0];
	endtask

	// ends on the negedge right after release
	task automatic apply_reset();
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
	endtask

	task automatic check_reset_values();
		check_flag("dna_read", dna_read, 1'b0);
		check_flag("dna_shift", dna_shift, 1'b0);
		check_flag("serial_valid", serial_valid, 1'b0);
		check_flag("idcode_valid", idcode_valid, 1'b0);
		check_flag("icap_csib", icap_csib, 1'b1);
		check_flag("icap_rdwrb", icap_rdwrb, 1'b1);
		check_serial("die_serial", die_serial, '0);
		check_idcode("idcode", idcode, '0);
	endtask

	// sync, two nops, read header, flush nops, later cmd header then desync
	task automatic check_log();
		int hdr_at;
		hdr_at = -1;
		if (accepted_q.size() < 7) begin
			$display("ICAP model accepted only %0d words, sequence incomplete",
				accepted_q.size());
			err_count++;
		end else begin
			check_word("accepted word 0", accepted_q[0], icap_cmd_pkg::sync_word);
			check_word("accepted word 1", accepted_q[1], icap_cmd_pkg::nop_word);
			check_word("accepted word 2", accepted_q[2], icap_cmd_pkg::nop_word);
			check_word("accepted word 3", accepted_q[3], icap_cmd_pkg::idcode_read_hdr);
			for (int i = 4; i < accepted_q.size(); i++)
				if (hdr_at < 0 && accepted_q[i] == icap_cmd_pkg::cmd_write_hdr)
					hdr_at = i;
			if (hdr_at < 5 || hdr_at + 1 >= accepted_q.size()) begin
				$display("ICAP model saw no flush NOPs or no desync after the read header");
				err_count++;
			end else begin
				for (int i = 4; i < hdr_at; i++)
					check_word($sformatf("accepted word %0d", i), accepted_q[i],
						icap_cmd_pkg::nop_word);
				check_word("word after cmd header", accepted_q[hdr_at+1],
					icap_cmd_pkg::desync_cmd);
			end
		end
	endtask

	task automatic run_test(input int idx, input bit abort);
		int errs_before;
		int cycles;
		int words_done;
		devinfo_types_pkg::die_serial_t exp_serial;
		errs_before = err_count;
		load_vector(idx);
		apply_reset();
		if (abort) begin
			// cut in once the port has turned around for reading
			while (icap_csib || !icap_rdwrb)
				@(negedge clk);
			load_vector(idx + 1);
			apply_reset();
		end
		check_reset_values();
		exp_serial = '0;
		exp_serial[devinfo_types_pkg::dna_bits-1:0] = cur_serial;
		cycles = 0;
		while (!serial_valid) begin
			@(posedge clk);
			cycles++;
			@(negedge clk);
			// icap still in its boot hold while dna reads
			if (!serial_valid)
				check_flag("icap_csib", icap_csib, 1'b1);
		end
		check_count("serial latency", cycles, dna_boot + 59);
		check_serial("die_serial", die_serial, exp_serial);
		while (!idcode_valid)
			@(negedge clk);
		check_idcode("idcode", idcode, cur_idcode);
		while (!(desync_seen && icap_csib))
			@(negedge clk);
		check_log();
		words_done = accepted_q.size();
		// port stays released afterwards
		repeat (16) begin
			@(negedge clk);
			check_flag("icap_csib", icap_csib, 1'b1);
		end
		check_count("accepted words", accepted_q.size(), words_done);
		check_count("dna_read pulses", read_pulses, 1);
		check_count("dna_shift cycles", shift_cycles, devinfo_types_pkg::dna_bits);
		tests_run++;
		if (err_count != errs_before)
			tests_failed++;
		$display("test %0d vector %0d%s: serial %h idcode %h %s", tests_run - 1,
			abort ? idx + 1 : idx, abort ? " after mid-read reset" : "",
			cur_serial, cur_idcode, (err_count == errs_before) ? "pass" : "fail");
	endtask

	initial begin
		int t;
		$readmemh("verification/device_info_vectors.txt", vectors);
		t = 0;
		while (t < num_tests) begin
			if (t == abort_at && t + 1 < num_tests) begin
				run_test(t, 1'b1);
				t += 2;
			end else begin
				run_test(t, 1'b0);
				t += 1;
			end
		end
		$display("tests run %0d, passed %0d, failed %0d, check errors %0d",
			tests_run, tests_run - tests_failed, tests_failed, err_count);
		if (err_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== verification/device_info_vectors.txt ====
// columns: 57-bit dna serial (15 hex digits), 32-bit jtag idcode (8 hex digits)
// one line per test, fed to the dna and icap models
1a5c3e7f0b29d46 0362d093
000000000000001 13631093
1ffffffffffffff 03727093
0a5a5a5a5a5a5a5 04b31093
155555555555555 0484a093
0f0e1d2c3b4a596 23727093
